//--- audio_reg_bank.sv
`timescale 1ns/100ps
`include "audio_spi_consts.svh"

module audio_reg_bank (
    input  logic                        clk,
    input  logic                        rst_n,
    input  audio_spi_pkg::reg_access_t  acc,
    output audio_spi_pkg::reg_data_t    rd_data,
    output audio_spi_pkg::ctrl_regs_t   regs,
    input  audio_spi_pkg::reg_data_t    audio_status,
    input  audio_spi_pkg::reg_data_t    sram_rd_data,
    input  audio_spi_pkg::reg_data_t    mpio_rd_data,
    input  audio_spi_pkg::reg_data_t    bit_cnt,
    input  logic [6:0]                  irq_hold,
    input  logic                        irq_pending,
    output logic                        irq_clear
);

    audio_spi_pkg::reg_data_t rd_mux;

    //////////////////////////////////////////////////////////////////////
    // write decode
    //////////////////////////////////////////////////////////////////////

    // coef and eq bytes are taken by the sequencer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (acc.wr) begin
            case (acc.addr)
                `REG_AUD_CONTROL:  regs.audio_control   <= acc.wdata;
                `REG_NUM_TAPS:     regs.taps_per_filter <= acc.wdata;
                `REG_FILTER_SEL:   regs.filter_select   <= acc.wdata;
                `REG_AUX:          regs.aux             <= acc.wdata;
                `REG_SRAM_CONTROL: regs.sram_control    <= acc.wdata;
                `REG_SRAM_ADDR:    regs.sram_start_addr <= acc.wdata;
                `REG_SPI_TO_SRAM:  regs.spi_to_sram     <= acc.wdata;
                `REG_MPIO_CONTROL: regs.mpio_control    <= acc.wdata;
                `REG_SPI_TO_MPIO:  regs.spi_to_mpio     <= acc.wdata;
                `REG_TEST:         regs.test            <= acc.wdata;
                default: ;                              // read only or unmapped
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read mux
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (acc.addr)
            `REG_AUD_CONTROL:  rd_mux = regs.audio_control;
            `REG_AUD_STATUS:   rd_mux = audio_status;
            `REG_NUM_TAPS:     rd_mux = regs.taps_per_filter;
            `REG_FILTER_SEL:   rd_mux = regs.filter_select;
            `REG_AUX:          rd_mux = regs.aux;
            `REG_SRAM_CONTROL: rd_mux = regs.sram_control;
            `REG_SRAM_ADDR:    rd_mux = regs.sram_start_addr;
            `REG_SPI_TO_SRAM:  rd_mux = regs.spi_to_sram;
            `REG_SRAM_TO_SPI:  rd_mux = sram_rd_data;     // straight from sram
            `REG_MPIO_CONTROL: rd_mux = regs.mpio_control;
            `REG_SPI_TO_MPIO:  rd_mux = regs.spi_to_mpio;
            `REG_MPIO_TO_SPI:  rd_mux = mpio_rd_data;     // pin state
            `REG_STATUS:       rd_mux = {irq_pending, audio_status[6:0]};
            `REG_TEST:         rd_mux = regs.test;
            `REG_INTERRUPT:    rd_mux = {1'b0, irq_hold};
            `REG_BIT_CNT:      rd_mux = bit_cnt;
            default:           rd_mux = `READ_DEFAULT;
        endcase
    end

    // sampled on the strobe, link picks it up next clk
    always_ff @(posedge clk) begin
        if (acc.rd) rd_data <= rd_mux;
    end

    //////////////////////////////////////////////////////////////////////
    // interrupt clear
    //////////////////////////////////////////////////////////////////////

    // one clk late so the held value is captured first
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq_clear <= 1'b0;
        end else begin
            irq_clear <= acc.rd && (acc.addr == `REG_INTERRUPT);
        end
    end

endmodule

//--- audio_spi_consts.svh
`ifndef AUDIO_SPI_CONSTS_SVH
`define AUDIO_SPI_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// widths and sizes
//////////////////////////////////////////////////////////////////////

`define ADDR_W          7       // register address, r/w bit not counted
`define DATA_W          8       // register data
`define NUM_FILTERS     4       // fir filters behind the coef port
`define MAX_TAPS        64      // tap index limit per filter

//////////////////////////////////////////////////////////////////////
// register map
//////////////////////////////////////////////////////////////////////

`define REG_AUD_CONTROL     7'h00   // audio control
`define REG_AUD_STATUS      7'h01   // audio status, from audio block
`define REG_NUM_TAPS        7'h02   // taps per filter
`define REG_FILTER_SEL      7'h03   // filter under access
`define REG_COEF_LSB        7'h04   // fir coef low byte
`define REG_COEF_MSB        7'h05   // fir coef high byte, issues the write
`define REG_AUX             7'h06
`define REG_SRAM_CONTROL    7'h07   // sram page
`define REG_SRAM_ADDR       7'h08   // sram start address
`define REG_SPI_TO_SRAM     7'h09   // data toward sram
`define REG_SRAM_TO_SPI     7'h0a   // data from sram
`define REG_MPIO_CONTROL    7'h0b   // mpio select and direction
`define REG_SPI_TO_MPIO     7'h0c   // data toward mpio pins
`define REG_MPIO_TO_SPI     7'h0d   // data from mpio pins
`define REG_EQ_LSB          7'h0e   // eq gain low byte
`define REG_EQ_MSB          7'h0f   // eq gain high byte, issues the write
`define REG_STATUS          7'h10   // {irq pending, audio status[6:0]}
`define REG_TEST            7'h11
`define REG_INTERRUPT       7'h12   // held irq sources, cleared by read
`define REG_BIT_CNT         7'h13   // i2s to pcm bit count

// unmapped reads
`define READ_DEFAULT        8'h99

`endif

//--- audio_spi_pkg.sv
`include "audio_spi_consts.svh"

package audio_spi_pkg;

    //////////////////////////////////////////////////////////////////////
    // scalar types
    //////////////////////////////////////////////////////////////////////

    typedef logic [`ADDR_W-1:0]                 reg_addr_t;
    typedef logic [`DATA_W-1:0]                 reg_data_t;
    typedef logic [$clog2(`MAX_TAPS)-1:0]       tap_idx_t;
    typedef logic [$clog2(`NUM_FILTERS)-1:0]    filt_idx_t;
    typedef logic [2*`DATA_W-1:0]               coef_t;     // {msb, lsb}

    // link to bank, strobes are one clk wide
    typedef struct packed {
        logic       rd;
        logic       wr;
        reg_addr_t  addr;
        reg_data_t  wdata;
    } reg_access_t;

    // host writable control registers
    typedef struct packed {
        reg_data_t audio_control;
        reg_data_t taps_per_filter;
        reg_data_t filter_select;
        reg_data_t aux;
        reg_data_t sram_control;
        reg_data_t sram_start_addr;
        reg_data_t spi_to_sram;
        reg_data_t mpio_control;
        reg_data_t spi_to_mpio;
        reg_data_t test;
    } ctrl_regs_t;

    // coef / gain write request toward the fir engine
    typedef struct packed {
        logic       valid;
        filt_idx_t  filter;
        tap_idx_t   tap;
        coef_t      data;
    } coef_wr_t;

    typedef enum logic [1:0] {IDLE, CMD, DATA, DONE} link_state_t;

endpackage

//--- audio_spi_top.sv
`timescale 1ns/100ps

module audio_spi_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        spi_cs_n,
    input  logic                        spi_sclk,
    input  logic                        spi_mosi,
    output logic                        spi_miso,
    output logic                        miso_oe,
    input  audio_spi_pkg::reg_data_t    audio_status,
    input  audio_spi_pkg::reg_data_t    sram_rd_data,
    input  audio_spi_pkg::reg_data_t    mpio_rd_data,
    input  audio_spi_pkg::reg_data_t    bit_cnt,
    input  logic [6:0]                  irq_sources,
    output audio_spi_pkg::ctrl_regs_t   regs,
    output audio_spi_pkg::coef_wr_t     coef_wr,
    output audio_spi_pkg::coef_wr_t     eq_wr,
    output logic                        irq_pending
);

    audio_spi_pkg::reg_access_t acc;        // link -> bank, sequencer
    audio_spi_pkg::reg_data_t   rd_data;
    logic [6:0]                 irq_hold;
    logic                       irq_clear;

    spi_slave_link u_link (
        .clk(clk), .rst_n(rst_n),
        .spi_cs_n(spi_cs_n), .spi_sclk(spi_sclk), .spi_mosi(spi_mosi),
        .spi_miso(spi_miso), .miso_oe(miso_oe),
        .acc(acc), .rd_data(rd_data)
    );

    audio_reg_bank u_bank (
        .clk(clk), .rst_n(rst_n), .acc(acc), .rd_data(rd_data), .regs(regs),
        .audio_status(audio_status), .sram_rd_data(sram_rd_data),
        .mpio_rd_data(mpio_rd_data), .bit_cnt(bit_cnt),
        .irq_hold(irq_hold), .irq_pending(irq_pending), .irq_clear(irq_clear)
    );

    irq_capture u_irq (
        .clk(clk), .rst_n(rst_n), .irq_sources(irq_sources), .irq_clear(irq_clear),
        .irq_hold(irq_hold), .irq_pending(irq_pending)
    );

    coef_write_sequencer u_coef (
        .clk(clk), .rst_n(rst_n), .acc(acc),
        .filter_select(regs.filter_select), .taps_per_filter(regs.taps_per_filter),
        .coef_wr(coef_wr), .eq_wr(eq_wr)
    );

endmodule

//--- coef_write_sequencer.sv
`timescale 1ns/100ps
`include "audio_spi_consts.svh"

module coef_write_sequencer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  audio_spi_pkg::reg_access_t  acc,
    input  audio_spi_pkg::reg_data_t    filter_select,
    input  audio_spi_pkg::reg_data_t    taps_per_filter,
    output audio_spi_pkg::coef_wr_t     coef_wr,
    output audio_spi_pkg::coef_wr_t     eq_wr
);

    audio_spi_pkg::reg_data_t  coef_lsb, eq_lsb;    // low bytes waiting for msb
    audio_spi_pkg::tap_idx_t   tap;                 // next coef tap
    audio_spi_pkg::filt_idx_t  filt;
    logic                      coef_msb_wr, eq_msb_wr;
    logic                      last_tap;

    // request payloads
    logic                      coef_vld, eq_vld;
    audio_spi_pkg::filt_idx_t  coef_filt, eq_filt;
    audio_spi_pkg::tap_idx_t   coef_tap;
    audio_spi_pkg::coef_t      coef_data, eq_data;

    assign filt        = audio_spi_pkg::filt_idx_t'(filter_select);
    assign coef_msb_wr = acc.wr && (acc.addr == `REG_COEF_MSB);
    assign eq_msb_wr   = acc.wr && (acc.addr == `REG_EQ_MSB);
    assign last_tap    = (audio_spi_pkg::reg_data_t'(tap) == taps_per_filter - 1'b1);

    // low bytes
    always_ff @(posedge clk) begin
        if (acc.wr && acc.addr == `REG_COEF_LSB) coef_lsb <= acc.wdata;
        if (acc.wr && acc.addr == `REG_EQ_LSB)   eq_lsb   <= acc.wdata;
    end

    //////////////////////////////////////////////////////////////////////
    // tap index and valids
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tap      <= '0;
            coef_vld <= 1'b0;
            eq_vld   <= 1'b0;
        end else begin
            coef_vld <= coef_msb_wr;
            eq_vld   <= eq_msb_wr;
            if (acc.wr && acc.addr == `REG_FILTER_SEL)
                tap <= '0;                          // new filter, start over
            else if (coef_msb_wr)
                tap <= last_tap ? '0 : tap + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (coef_msb_wr) begin
            coef_filt <= filt;
            coef_tap  <= tap;
            coef_data <= {acc.wdata, coef_lsb};
        end
        if (eq_msb_wr) begin
            eq_filt <= filt;
            eq_data <= {acc.wdata, eq_lsb};
        end
    end

    assign coef_wr = '{valid: coef_vld, filter: coef_filt, tap: coef_tap, data: coef_data};
    assign eq_wr   = '{valid: eq_vld, filter: eq_filt, tap: '0, data: eq_data};  // one gain per filter

endmodule

//--- irq_capture.sv
`timescale 1ns/100ps

module irq_capture (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [6:0]  irq_sources,
    input  logic        irq_clear,
    output logic [6:0]  irq_hold,
    output logic        irq_pending
);

    logic [6:0] src_last;       // sources seen last clk
    logic       src_change;

    // any edge on any source, either direction
    assign src_change = (irq_sources != src_last);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            src_last <= '0;
        end else begin
            src_last <= irq_sources;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // hold and pending
    //////////////////////////////////////////////////////////////////////

    // a change in the clear cycle wins, nothing gets lost
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq_hold    <= '0;
            irq_pending <= 1'b0;
        end else if (src_change) begin
            irq_hold    <= irq_sources;     // latest source state
            irq_pending <= 1'b1;
        end else if (irq_clear) begin
            irq_hold    <= '0;              // host has read INTERRUPT
            irq_pending <= 1'b0;
        end
    end

    // sources still set after clear stay quiet
    // until they change again

endmodule

//--- project.f
+incdir+.
audio_spi_pkg.sv
spi_slave_link.sv
irq_capture.sv
coef_write_sequencer.sv
audio_reg_bank.sv
audio_spi_top.sv
tb_audio_spi.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    -f project.f --top-module tb_audio_spi -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "run failed, see sim.log"
    exit 1
fi
echo "run passed"

//--- spi_slave_link.sv
`timescale 1ns/100ps
`include "audio_spi_consts.svh"

module spi_slave_link (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        spi_cs_n,
    input  logic                        spi_sclk,
    input  logic                        spi_mosi,
    output logic                        spi_miso,
    output logic                        miso_oe,
    output audio_spi_pkg::reg_access_t  acc,
    input  audio_spi_pkg::reg_data_t    rd_data
);

    audio_spi_pkg::link_state_t state;

    logic [2:0] sclk_q;                         // 2 sync flops + previous
    logic [1:0] cs_q;
    logic [1:0] mosi_q;
    logic       rise_p, fall_p;                 // registered edge pulses
    logic       cs_act;
    logic       mosi_s;

    logic [$clog2(`DATA_W)-1:0] bit_cnt;        // bits within current byte
    logic       last_bit;
    logic       rd_bit;                         // frame is a read
    logic       cmd_done, data_done;
    logic       rd_stb, wr_stb, rd_q;

    audio_spi_pkg::reg_data_t rx_sr, tx_sr;
    audio_spi_pkg::reg_addr_t addr_r;
    audio_spi_pkg::reg_data_t wdata_r;

    assign cs_act   = ~cs_q[1];
    assign mosi_s   = mosi_q[1];
    assign last_bit = rise_p && (bit_cnt == '1);

    //////////////////////////////////////////////////////////////////////
    // pin sync and edge detect
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sclk_q <= '0;
            cs_q   <= '1;                       // deselected
            mosi_q <= '0;
            rise_p <= 1'b0;
            fall_p <= 1'b0;
        end else begin
            sclk_q <= {sclk_q[1:0], spi_sclk};
            cs_q   <= {cs_q[0], spi_cs_n};
            mosi_q <= {mosi_q[0], spi_mosi};
            rise_p <= sclk_q[1] & ~sclk_q[2];
            fall_p <= ~sclk_q[1] & sclk_q[2];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // frame fsm
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= audio_spi_pkg::IDLE;
            bit_cnt   <= '0;
            rd_bit    <= 1'b0;
            cmd_done  <= 1'b0;
            data_done <= 1'b0;
        end else begin
            cmd_done  <= 1'b0;
            data_done <= 1'b0;
            if (!cs_act) begin                  // cs_n high ends or aborts the frame
                state   <= audio_spi_pkg::IDLE;
                bit_cnt <= '0;
            end else begin
                case (state)
                    audio_spi_pkg::IDLE: begin
                        state   <= audio_spi_pkg::CMD;
                        bit_cnt <= '0;
                    end
                    audio_spi_pkg::CMD: if (rise_p) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (last_bit) begin
                            rd_bit   <= rx_sr[6];   // first bit of the command
                            state    <= audio_spi_pkg::DATA;
                            cmd_done <= 1'b1;
                        end
                    end
                    audio_spi_pkg::DATA: if (rise_p) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (last_bit) begin
                            state     <= audio_spi_pkg::DONE;
                            data_done <= 1'b1;
                        end
                    end
                    default: ;                  // DONE, wait for cs_n
                endcase
            end
        end
    end

    // mosi shift and byte capture
    always_ff @(posedge clk) begin
        if (rise_p) rx_sr <= {rx_sr[6:0], mosi_s};
        if (last_bit && state == audio_spi_pkg::CMD) addr_r <= {rx_sr[5:0], mosi_s};
        if (last_bit && state == audio_spi_pkg::DATA) wdata_r <= {rx_sr[6:0], mosi_s};
    end

    // strobes, one clk after the byte is complete
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_stb <= 1'b0;
            wr_stb <= 1'b0;
            rd_q   <= 1'b0;
        end else begin
            rd_stb <= cmd_done & rd_bit;
            wr_stb <= data_done & ~rd_bit;
            rd_q   <= rd_stb;                   // bank data ready
        end
    end

    assign acc = '{rd: rd_stb, wr: wr_stb, addr: addr_r, wdata: wdata_r};

    //////////////////////////////////////////////////////////////////////
    // miso side
    //////////////////////////////////////////////////////////////////////

    // first data falling edge is skipped so bit 7 holds until the 9th rise
    always_ff @(posedge clk) begin
        if (rd_q)
            tx_sr <= rd_data;
        else if (fall_p && state == audio_spi_pkg::DATA && bit_cnt != '0)
            tx_sr <= {tx_sr[6:0], 1'b0};
    end

    assign miso_oe  = (state == audio_spi_pkg::DATA) & rd_bit;
    assign spi_miso = miso_oe ? tx_sr[7] : 1'b0;    // low when not driven

endmodule

//--- tb_audio_spi.sv
`timescale 1ns/100ps
`include "audio_spi_consts.svh"

module tb_audio_spi;

    localparam int HALF = 8;                    // clk per sclk half period
    localparam logic [7:0] AUD_STAT = 8'h5a;    // fixed top-level read values
    localparam logic [7:0] SRAM_VAL = 8'hc3;
    localparam logic [7:0] MPIO_VAL = 8'h3c;
    localparam logic [7:0] BITS_VAL = 8'h18;

    localparam logic [2:0] OP_WR    = 3'd0;     // write frame then check the regs field
    localparam logic [2:0] OP_RD    = 3'd1;     // read frame then check the returned byte
    localparam logic [2:0] OP_COEF  = 3'd2;     // coef lsb/msb pair
    localparam logic [2:0] OP_EQ    = 3'd3;     // eq gain lsb/msb pair
    localparam logic [2:0] OP_IRQ   = 3'd4;     // change irq_sources
    localparam logic [2:0] OP_PEND  = 3'd5;     // check irq_pending level
    localparam logic [2:0] OP_SHORT = 3'd6;     // frame aborted after 5 bits

    // exp holds {filter, tap} for coef and eq rows
    typedef struct packed {
        logic [2:0]  op;
        logic [6:0]  addr;
        logic [15:0] data;
        logic [7:0]  exp;
    } row_t;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       spi_cs_n;
    logic       spi_sclk;
    logic       spi_mosi;
    logic       spi_miso;
    logic       miso_oe;
    logic [6:0] irq_sources;
    logic       irq_pending;
    audio_spi_pkg::reg_data_t  audio_status;
    audio_spi_pkg::reg_data_t  sram_rd_data;
    audio_spi_pkg::reg_data_t  mpio_rd_data;
    audio_spi_pkg::reg_data_t  bit_cnt;
    audio_spi_pkg::ctrl_regs_t regs;
    audio_spi_pkg::coef_wr_t   coef_wr;
    audio_spi_pkg::coef_wr_t   eq_wr;

    row_t       tbl [64];
    logic [7:0] shadow [0:127];                 // last value written per address
    integer     seed;
    int         num_rows = 0;
    int         err_cnt = 0;
    int         fail_rows = 0;
    int         cycles = 0;
    int         limit = 0;
    int         coef_cnt;                       // valid pulses seen
    int         eq_cnt;
    audio_spi_pkg::coef_wr_t coef_last;         // most recent request of each kind
    audio_spi_pkg::coef_wr_t eq_last;

    always #50 clk = ~clk;                      // 100 ns

    audio_spi_top UUT (
        .clk(clk), .rst_n(rst_n),
        .spi_cs_n(spi_cs_n), .spi_sclk(spi_sclk), .spi_mosi(spi_mosi),
        .spi_miso(spi_miso), .miso_oe(miso_oe),
        .audio_status(audio_status), .sram_rd_data(sram_rd_data),
        .mpio_rd_data(mpio_rd_data), .bit_cnt(bit_cnt), .irq_sources(irq_sources),
        .regs(regs), .coef_wr(coef_wr), .eq_wr(eq_wr), .irq_pending(irq_pending)
    );

    //////////////////////////////////////////////////////////////////////
    // monitors and timeout
    //////////////////////////////////////////////////////////////////////

    // registered outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            coef_cnt = 0;
            eq_cnt   = 0;
        end else begin
            if (coef_wr.valid) begin
                coef_cnt  = coef_cnt + 1;
                coef_last = coef_wr;
            end
            if (eq_wr.valid) begin
                eq_cnt  = eq_cnt + 1;
                eq_last = eq_wr;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #5;                                     // drive just after the edge
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] exp,
                                   input logic [15:0] got);
        $display("ERR t=%0t %s exp=%h got=%h", $time, name, exp, got);
        err_cnt++;
    endtask

    task automatic report_problem(input string msg);
        $display("problem at t=%0t: %s", $time, msg);
        err_cnt++;
    endtask

    // mode 0 msb first with miso sampled at the end of each low phase
    task automatic spi_frame(input logic rd, input logic [6:0] addr, input logic [7:0] wdata,
                             input int nbits, output logic [7:0] rdata);
        logic [15:0] frame;
        int          i;
        frame    = {rd, addr, wdata};
        rdata    = 8'h00;
        spi_cs_n = 1'b0;
        step(HALF);
        for (i = 0; i < nbits; i++) begin
            spi_mosi = frame[15-i];
            step(HALF);
            if (i < 8 && miso_oe !== 1'b0)
                report_problem("miso_oe high during the command byte");
            if (i >= 8 && miso_oe !== rd)
                report_mismatch("miso_oe", {15'h0, rd}, {15'h0, miso_oe});
            if (i >= 8)
                rdata = {rdata[6:0], spi_miso};
            spi_sclk = 1'b1;
            step(HALF);
            spi_sclk = 1'b0;
        end
        step(HALF);
        spi_cs_n = 1'b1;
        spi_mosi = 1'b0;
        step(HALF);                             // cs_n synced and link back in idle
        if (miso_oe !== 1'b0)
            report_problem("miso_oe still high after the frame ended");
    endtask

    function automatic logic [6:0] ctrl_addr(input int i);
        case (i)
            0:       return `REG_AUD_CONTROL;
            1:       return `REG_NUM_TAPS;
            2:       return `REG_FILTER_SEL;
            3:       return `REG_AUX;
            4:       return `REG_SRAM_CONTROL;
            5:       return `REG_SRAM_ADDR;
            6:       return `REG_SPI_TO_SRAM;
            7:       return `REG_MPIO_CONTROL;
            8:       return `REG_SPI_TO_MPIO;
            default: return `REG_TEST;
        endcase
    endfunction

    function automatic logic [7:0] field_of(input logic [6:0] addr);
        case (addr)
            `REG_AUD_CONTROL:  return regs.audio_control;
            `REG_NUM_TAPS:     return regs.taps_per_filter;
            `REG_FILTER_SEL:   return regs.filter_select;
            `REG_AUX:          return regs.aux;
            `REG_SRAM_CONTROL: return regs.sram_control;
            `REG_SRAM_ADDR:    return regs.sram_start_addr;
            `REG_SPI_TO_SRAM:  return regs.spi_to_sram;
            `REG_MPIO_CONTROL: return regs.mpio_control;
            `REG_SPI_TO_MPIO:  return regs.spi_to_mpio;
            `REG_TEST:         return regs.test;
            default:           return 8'h00;
        endcase
    endfunction

    task automatic add_row(input logic [2:0] op, input logic [6:0] addr,
                           input logic [15:0] data, input logic [7:0] exp);
        tbl[num_rows] = '{op: op, addr: addr, data: data, exp: exp};
        num_rows++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////////////////////////

    task automatic build_table();
        int          i;
        logic [6:0]  a;
        logic [31:0] rnd;
        for (i = 0; i < 10; i++) begin          // random writes then read back
            rnd       = $random(seed);
            a         = ctrl_addr(i);
            shadow[a] = rnd[7:0];
            add_row(OP_WR, a, {8'h00, rnd[7:0]}, rnd[7:0]);
        end
        for (i = 0; i < 10; i++)
            add_row(OP_RD, ctrl_addr(i), 16'h0000, shadow[ctrl_addr(i)]);
        add_row(OP_RD, `REG_SRAM_TO_SPI, 16'h0000, SRAM_VAL);
        add_row(OP_RD, `REG_MPIO_TO_SPI, 16'h0000, MPIO_VAL);
        add_row(OP_RD, `REG_AUD_STATUS, 16'h0000, AUD_STAT);
        add_row(OP_RD, `REG_BIT_CNT, 16'h0000, BITS_VAL);
        add_row(OP_RD, 7'h55, 16'h0000, `READ_DEFAULT);    // unmapped
        add_row(OP_RD, `REG_STATUS, 16'h0000, {1'b0, AUD_STAT[6:0]});
        add_row(OP_WR, `REG_NUM_TAPS, 16'h0003, 8'h03);
        add_row(OP_WR, `REG_FILTER_SEL, 16'h0002, 8'h02);
        for (i = 0; i < 4; i++) begin
            rnd = $random(seed);
            add_row(OP_COEF, 7'h00, rnd[15:0], {2'd2, 6'(i % 3)}); // taps 0 1 2 0
        end
        rnd = $random(seed);
        add_row(OP_EQ, 7'h00, rnd[15:0], {2'd2, 6'd0});
        add_row(OP_IRQ, 7'h00, 16'h0025, 8'h01);
        add_row(OP_RD, `REG_STATUS, 16'h0000, {1'b1, AUD_STAT[6:0]});
        add_row(OP_RD, `REG_INTERRUPT, 16'h0000, 8'h25);
        add_row(OP_PEND, 7'h00, 16'h0000, 8'h00);          // cleared by the read
        add_row(OP_RD, `REG_INTERRUPT, 16'h0000, 8'h00);
        // link left holding the AUX address and an inverted data byte
        add_row(OP_RD, `REG_AUX, {8'h00, ~shadow[`REG_AUX]}, shadow[`REG_AUX]);
        add_row(OP_SHORT, `REG_AUX, {8'h00, ~shadow[`REG_AUX]}, 8'h00);
        add_row(OP_RD, `REG_AUX, 16'h0000, shadow[`REG_AUX]);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int                        r;
        int                        errs_before;
        int                        c0;
        int                        e0;
        row_t                      row;
        logic [7:0]                rdata;
        audio_spi_pkg::coef_wr_t   pulse;
        audio_spi_pkg::ctrl_regs_t snap;
        rst_n        = 1'b0;
        spi_cs_n     = 1'b1;
        spi_sclk     = 1'b0;
        spi_mosi     = 1'b0;
        irq_sources  = 7'h00;
        audio_status = AUD_STAT;
        sram_rd_data = SRAM_VAL;
        mpio_rd_data = MPIO_VAL;
        bit_cnt      = BITS_VAL;
        seed         = 32'hd8c4;
        build_table();
        limit = num_rows * 400 + 1000;
        step(10);
        rst_n = 1'b1;
        step(4);
        for (r = 0; r < num_rows; r++) begin
            row         = tbl[r];
            errs_before = err_cnt;
            case (row.op)
                OP_WR: begin
                    spi_frame(1'b0, row.addr, row.data[7:0], 16, rdata);
                    if (field_of(row.addr) !== row.exp)
                        report_mismatch("regs field", {8'h00, row.exp},
                                        {8'h00, field_of(row.addr)});
                end
                OP_RD: begin
                    spi_frame(1'b1, row.addr, row.data[7:0], 16, rdata);
                    if (rdata !== row.exp)
                        report_mismatch("spi_miso byte", {8'h00, row.exp}, {8'h00, rdata});
                end
                OP_COEF, OP_EQ: begin
                    c0 = coef_cnt;
                    e0 = eq_cnt;
                    spi_frame(1'b0, row.op == OP_COEF ? `REG_COEF_LSB : `REG_EQ_LSB,
                              row.data[7:0], 16, rdata);
                    spi_frame(1'b0, row.op == OP_COEF ? `REG_COEF_MSB : `REG_EQ_MSB,
                              row.data[15:8], 16, rdata);
                    pulse = (row.op == OP_COEF) ? coef_last : eq_last;
                    if (coef_cnt != c0 + (row.op == OP_COEF ? 1 : 0))
                        report_problem("wrong number of coef_wr pulses for this pair");
                    if (eq_cnt != e0 + (row.op == OP_EQ ? 1 : 0))
                        report_problem("wrong number of eq_wr pulses for this pair");
                    if (pulse.filter !== row.exp[7:6])
                        report_mismatch("wr.filter", {14'h0, row.exp[7:6]},
                                        {14'h0, pulse.filter});
                    if (pulse.tap !== row.exp[5:0])
                        report_mismatch("wr.tap", {10'h0, row.exp[5:0]}, {10'h0, pulse.tap});
                    if (pulse.data !== row.data)
                        report_mismatch("wr.data", row.data, pulse.data);
                end
                OP_IRQ: begin
                    irq_sources = row.data[6:0];
                    step(1);                            // pending one clk after the change
                    if (irq_pending !== row.exp[0])
                        report_mismatch("irq_pending", {15'h0, row.exp[0]}, {15'h0, irq_pending});
                end
                OP_PEND: begin
                    if (irq_pending !== row.exp[0])
                        report_mismatch("irq_pending", {15'h0, row.exp[0]}, {15'h0, irq_pending});
                end
                OP_SHORT: begin
                    snap = regs;
                    spi_frame(1'b0, row.addr, row.data[7:0], 5, rdata);
                    if (regs !== snap)
                        report_problem("a control register changed after a cut-short frame");
                end
                default: report_problem("unknown op code in the stimulus table");
            endcase
            if (err_cnt != errs_before)
                fail_rows++;
            $display("row %0d op %0d addr %h: %s", r, row.op, row.addr,
                     (err_cnt == errs_before) ? "ok" : "failed");
        end
        $display("rows %0d, rows failed %0d, errors %0d", num_rows, fail_rows, err_cnt);
        if (err_cnt == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule
